// File: bench/decoderChecker.sv
`timescale 1ns/10ps
`default_nettype none

module decoderChecker
    import decodePkg::*;
(
    input wire logic clk,
    input wire logic rstN,
    input wire logic check,
    input wire instrWord instr,
    input wire regUseT expRegUse,
    input wire logic expRegWrite,
    input wire aluSrcT expAluSrc,
    input wire immTypeT expImmType,
    input wire aluFuncT expAluFunc,
    input wire logic expMemRead,
    input wire logic expMemWrite,
    input wire logic expMemToReg,
    input wire memSizeT expMemSize,
    input wire wbTypeT expWbType,
    input wire branchT expBranchType,
    input wire logic expInstrMisalign,
    input wire regUseT regUse,
    input wire logic regWrite,
    input wire aluSrcT aluSrc,
    input wire immTypeT immType,
    input wire aluFuncT aluFunc,
    input wire logic memRead,
    input wire logic memWrite,
    input wire logic memToReg,
    input wire memSizeT memSize,
    input wire wbTypeT wbType,
    input wire branchT branchType,
    input wire logic instrMisalign,
    output int errorCount,
    output int checkCount
);

    task automatic compareField(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected 'h%0h actual 'h%0h (instr %h)",
                     name, expected, actual, instr);
            errorCount++;
        end
    endtask

    // the eleven opcodes this decoder accepts
    function automatic logic knownOpcode(input opcodeT op);
        logic known;
        case (op)
            opOpImm, opOp, opOpImm32, opOp32: known = 1'b1;
            opLoad, opStore, opBranch: known = 1'b1;
            opLui, opAuipc, opJal, opJalr: known = 1'b1;
            default: known = 1'b0;
        endcase
        return known;
    endfunction

    always @(posedge clk) begin
        if (!rstN) begin
            errorCount = 0;
            checkCount = 0;
        end else begin
            if (check) begin
                checkCount++;
                compareField("regUse", expRegUse, regUse);
                compareField("regWrite", expRegWrite, regWrite);
                compareField("aluSrc", expAluSrc, aluSrc);
                compareField("immType", expImmType, immType);
                compareField("aluFunc", expAluFunc, aluFunc);
                compareField("memRead", expMemRead, memRead);
                compareField("memWrite", expMemWrite, memWrite);
                compareField("memToReg", expMemToReg, memToReg);
                compareField("memSize", expMemSize, memSize);
                compareField("wbType", expWbType, wbType);
                compareField("branchType", expBranchType, branchType);
                compareField("instrMisalign", expInstrMisalign, instrMisalign);
            end
            if (memRead && memWrite) begin
                $display("memory read and write are both enabled for instr %h", instr);
                errorCount++;
            end
            if (regWrite && !knownOpcode(instr[6:0])) begin
                $display("register write is enabled for an illegal instr %h", instr);
                errorCount++;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/decoderTb.sv
`timescale 1ns/10ps
`default_nettype none

module decoderTb
    import decodePkg::*;
();

    localparam int clkPeriod = 40;
    localparam int resetCycles = 8;
    localparam int maxRows = 80;
    localparam dword basePc = 64'h0000_0000_8000_1000;

    typedef struct packed {
        dword pc;
        instrWord instr;
        regUseT regUse;
        logic regWrite;
        aluSrcT aluSrc;
        immTypeT immType;
        aluFuncT aluFunc;
        logic memRead;
        logic memWrite;
        logic memToReg;
        memSizeT memSize;
        wbTypeT wbType;
        branchT branchType;
        logic instrMisalign;
    } rowT;

    logic clk;
    logic rstN;
    dword pc;
    instrWord instr;
    regUseT regUse;
    logic regWrite;
    aluSrcT aluSrc;
    immTypeT immType;
    aluFuncT aluFunc;
    logic memRead;
    logic memWrite;
    logic memToReg;
    memSizeT memSize;
    wbTypeT wbType;
    branchT branchType;
    logic instrMisalign;

    rowT rows [maxRows];
    rowT expected;
    int rowCount;
    logic check;
    logic tableReady;
    int errorCount;
    int checkCount;

    tbClock #(.period(clkPeriod), .resetCycles(resetCycles)) clock_i (
        .clk(clk),
        .rstN(rstN)
    );

    rv64Decoder dut_i (
        .pc(pc),
        .instr(instr),
        .regUse(regUse),
        .regWrite(regWrite),
        .aluSrc(aluSrc),
        .immType(immType),
        .aluFunc(aluFunc),
        .memRead(memRead),
        .memWrite(memWrite),
        .memToReg(memToReg),
        .memSize(memSize),
        .wbType(wbType),
        .branchType(branchType),
        .instrMisalign(instrMisalign)
    );

    decoderChecker check_i (
        .clk(clk),
        .rstN(rstN),
        .check(check),
        .instr(instr),
        .expRegUse(expected.regUse),
        .expRegWrite(expected.regWrite),
        .expAluSrc(expected.aluSrc),
        .expImmType(expected.immType),
        .expAluFunc(expected.aluFunc),
        .expMemRead(expected.memRead),
        .expMemWrite(expected.memWrite),
        .expMemToReg(expected.memToReg),
        .expMemSize(expected.memSize),
        .expWbType(expected.wbType),
        .expBranchType(expected.branchType),
        .expInstrMisalign(expected.instrMisalign),
        .regUse(regUse),
        .regWrite(regWrite),
        .aluSrc(aluSrc),
        .immType(immType),
        .aluFunc(aluFunc),
        .memRead(memRead),
        .memWrite(memWrite),
        .memToReg(memToReg),
        .memSize(memSize),
        .wbType(wbType),
        .branchType(branchType),
        .instrMisalign(instrMisalign),
        .errorCount(errorCount),
        .checkCount(checkCount)
    );

    // rd = x1, rs1 = x2, rs2 = x3 throughout
    function automatic instrWord encodeR(input logic [6:0] f7, input funct3T f3,
                                         input opcodeT op);
        return {f7, 5'd3, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic instrWord encodeI(input logic [11:0] imm, input funct3T f3,
                                         input opcodeT op);
        return {imm, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic instrWord encodeU(input logic [19:0] imm, input opcodeT op);
        return {imm, 5'd1, op};
    endfunction

    // new aligned row with the memory fields idle and no branch
    task automatic addRow(input dword rowPc, input instrWord rowInstr, input regUseT ru,
                          input logic rw, input aluSrcT src, input immTypeT imm,
                          input aluFuncT fn);
        rowT r;
        r = '0;
        r.pc = rowPc;
        r.instr = rowInstr;
        r.regUse = ru;
        r.regWrite = rw;
        r.aluSrc = src;
        r.immType = imm;
        r.aluFunc = fn;
        r.memSize = sizeNone;
        r.wbType = wbNone;
        r.branchType = noBranch;
        r.instrMisalign = 1'b0;
        rows[rowCount] = r;
        rowCount++;
    endtask

    task automatic setMem(input logic rd, input logic wr, input logic toReg,
                          input memSizeT size, input wbTypeT wb);
        rowT r;
        r = rows[rowCount - 1];
        r.memRead = rd;
        r.memWrite = wr;
        r.memToReg = toReg;
        r.memSize = size;
        r.wbType = wb;
        rows[rowCount - 1] = r;
    endtask

    task automatic setBranch(input branchT br);
        rowT r;
        r = rows[rowCount - 1];
        r.branchType = br;
        rows[rowCount - 1] = r;
    endtask

    task automatic setMisalign();
        rowT r;
        r = rows[rowCount - 1];
        r.instrMisalign = 1'b1;
        rows[rowCount - 1] = r;
    endtask

    task automatic regOpRow(input instrWord rowInstr, input aluFuncT fn);
        addRow(basePc, rowInstr, rs1AndRs2, 1'b1, fromReg, noImm, fn);
    endtask

    task automatic immOpRow(input instrWord rowInstr, input aluSrcT src,
                            input immTypeT imm, input aluFuncT fn);
        addRow(basePc, rowInstr, rs1Only, 1'b1, src, imm, fn);
    endtask

    task automatic loadRow(input funct3T f3, input logic active, input memSizeT size,
                           input wbTypeT wb);
        addRow(basePc, encodeI(12'h010, f3, opLoad), rs1Only, 1'b1, fromImm, immI, aluAdd);
        setMem(active, 1'b0, active, size, wb);
    endtask

    task automatic storeRow(input funct3T f3, input logic active, input memSizeT size);
        addRow(basePc, encodeR(7'h00, f3, opStore), rs1AndRs2, 1'b0, fromImm, immS, aluAdd);
        setMem(1'b0, active, 1'b0, size, wbNone);
    endtask

    task automatic branchRow(input funct3T f3, input branchT br);
        addRow(basePc, encodeR(7'h00, f3, opBranch), rs1AndRs2, 1'b0, fromReg, immB,
               aluBranch);
        setBranch(br);
    endtask

    task automatic buildTable();
        // bit 30 picks sub and sra in OP
        regOpRow(encodeR(7'h00, f3AddSub, opOp), aluAdd);
        regOpRow(encodeR(7'h20, f3AddSub, opOp), aluSub);
        regOpRow(encodeR(7'h00, f3Sll, opOp), aluSll);
        regOpRow(encodeR(7'h00, f3Slt, opOp), aluSLess);
        regOpRow(encodeR(7'h00, f3Sltu, opOp), aluULess);
        regOpRow(encodeR(7'h00, f3Xor, opOp), aluXor);
        regOpRow(encodeR(7'h00, f3SrlSra, opOp), aluSrl);
        regOpRow(encodeR(7'h20, f3SrlSra, opOp), aluSra);
        regOpRow(encodeR(7'h00, f3Or, opOp), aluOr);
        regOpRow(encodeR(7'h00, f3And, opOp), aluAnd);
        regOpRow(encodeR(7'h00, f3AddSub, opOp32), aluAddw);
        regOpRow(encodeR(7'h20, f3AddSub, opOp32), aluSubw);
        regOpRow(encodeR(7'h00, f3Sll, opOp32), aluSllw);
        regOpRow(encodeR(7'h00, f3SrlSra, opOp32), aluSrlw);
        regOpRow(encodeR(7'h20, f3SrlSra, opOp32), aluSraw);
        // an immediate with bit 30 set is still an add
        immOpRow(encodeI(12'h07f, f3AddSub, opOpImm), fromImm, immI, aluAdd);
        immOpRow(encodeI(12'h400, f3AddSub, opOpImm), fromImm, immI, aluAdd);
        immOpRow(encodeI(12'hff0, f3Slt, opOpImm), fromImm, immI, aluSLess);
        immOpRow(encodeI(12'h001, f3Sltu, opOpImm), fromImm, immI, aluULess);
        immOpRow(encodeI(12'h0aa, f3Xor, opOpImm), fromImm, immI, aluXor);
        immOpRow(encodeI(12'h055, f3Or, opOpImm), fromImm, immI, aluOr);
        immOpRow(encodeI(12'h00f, f3And, opOpImm), fromImm, immI, aluAnd);
        immOpRow(encodeI(12'h003, f3Sll, opOpImm), fromShamt, noImm, aluSll);
        immOpRow(encodeI(12'h005, f3SrlSra, opOpImm), fromShamt, noImm, aluSrl);
        immOpRow(encodeI(12'h405, f3SrlSra, opOpImm), fromShamt, noImm, aluSra);
        immOpRow(encodeI(12'h010, f3AddSub, opOpImm32), fromImm, immI, aluAddw);
        immOpRow(encodeI(12'h003, f3Sll, opOpImm32), fromShamt, noImm, aluSllw);
        immOpRow(encodeI(12'h005, f3SrlSra, opOpImm32), fromShamt, noImm, aluSrlw);
        immOpRow(encodeI(12'h405, f3SrlSra, opOpImm32), fromShamt, noImm, aluSraw);
        immOpRow(encodeI(12'h010, f3Slt, opOpImm32), noSrc, noImm, aluUnknown);
        loadRow(f3Lb, 1'b1, size8, wb7Sext);
        loadRow(f3Lh, 1'b1, size16, wb15Sext);
        loadRow(f3Lw, 1'b1, size32, wb31Sext);
        loadRow(f3Ld, 1'b1, size64, wb63);
        loadRow(f3Lbu, 1'b1, size8, wb7Zext);
        loadRow(f3Lhu, 1'b1, size16, wb15Zext);
        loadRow(f3Lwu, 1'b1, size32, wb31Zext);
        // undefined widths only clear the memory side
        loadRow(3'b111, 1'b0, sizeNone, wbNone);
        storeRow(f3Sb, 1'b1, size8);
        storeRow(f3Sh, 1'b1, size16);
        storeRow(f3Sw, 1'b1, size32);
        storeRow(f3Sd, 1'b1, size64);
        storeRow(3'b100, 1'b0, sizeNone);
        branchRow(f3Beq, brEq);
        branchRow(f3Bne, brNe);
        branchRow(f3Blt, brLessS);
        branchRow(f3Bge, brGeS);
        branchRow(f3Bltu, brLessU);
        branchRow(f3Bgeu, brGeU);
        branchRow(3'b010, noBranch);
        addRow(basePc, encodeU(20'h00010, opJal), noRegs, 1'b1, fromPcAdd4, immJ, aluLink);
        setBranch(brJal);
        addRow(basePc, encodeI(12'h008, 3'b000, opJalr), rs1Only, 1'b1, fromPcAdd4, immI,
               aluLink);
        setBranch(brJalr);
        addRow(basePc, encodeU(20'h12345, opLui), noRegs, 1'b1, fromImm, immU, aluLink);
        addRow(basePc, encodeU(20'h00001, opAuipc), noRegs, 1'b1, fromPcAddImm, immU,
               aluLink);
        // misaligned pc on top of a normal decode
        addRow(basePc + 64'h1, encodeR(7'h00, f3AddSub, opOp), rs1AndRs2, 1'b1, fromReg,
               noImm, aluAdd);
        setMisalign();
        addRow(basePc + 64'h2, encodeI(12'h020, f3Lw, opLoad), rs1Only, 1'b1, fromImm,
               immI, aluAdd);
        setMem(1'b1, 1'b0, 1'b1, size32, wb31Sext);
        setMisalign();
        addRow(basePc + 64'h3, encodeU(20'h00020, opJal), noRegs, 1'b1, fromPcAdd4, immJ,
               aluLink);
        setBranch(brJal);
        setMisalign();
        // SYSTEM, FENCE and an all-ones word are illegal here
        addRow(basePc, 32'h0000_0073, noRegs, 1'b0, fromReg, noImm, aluUnknown);
        addRow(basePc, 32'h0000_000f, noRegs, 1'b0, fromReg, noImm, aluUnknown);
        addRow(basePc, 32'hffff_ffff, noRegs, 1'b0, fromReg, noImm, aluUnknown);
    endtask

    initial begin
        pc = '0;
        instr = '0;
        check = 1'b0;
        expected = '0;
        rowCount = 0;
        tableReady = 1'b0;
        buildTable();
        tableReady = 1'b1;
        wait (rstN === 1'b1);
        for (int i = 0; i < rowCount; i++) begin
            @(negedge clk);
            pc = rows[i].pc;
            instr = rows[i].instr;
            expected = rows[i];
            check = 1'b1;
        end
        // last row was compared on the rising edge before this one
        @(negedge clk);
        check = 1'b0;
        $display("%0d of %0d rows checked, %0d errors", checkCount, rowCount, errorCount);
        if (errorCount == 0 && checkCount == rowCount) begin
            $display("All checks passed");
        end else begin
            if (checkCount != rowCount) begin
                $display("not every table row reached the checker");
            end
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (tableReady === 1'b1);
        #((resetCycles + rowCount + 10) * clkPeriod);
        $display("test timed out before all table rows were applied");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
    parameter int period = 40,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release on a falling edge away from the sampling edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: project.f
src/decodePkg.sv
src/instrFormatDecode.sv
src/aluFuncDecode.sv
src/memAccessDecode.sv
src/branchDecode.sv
src/rv64Decoder.sv
bench/tbClock.sv
bench/decoderChecker.sv
bench/decoderTb.sv

// File: src/aluFuncDecode.sv
`timescale 1ns/10ps
`default_nettype none

module aluFuncDecode
    import decodePkg::*;
(
    input wire instrGroup group,
    input wire funct3T funct3,
    input wire logic funct7Bit,
    output aluFuncT aluFunc
);

    // 64-bit ops; the immediate form has no sub since bit 30 is immediate data there
    function automatic aluFuncT fullTable(input funct3T f3, input logic alt,
                                          input logic allowSub);
        aluFuncT func;
        unique case (f3)
            f3AddSub: func = (allowSub && alt) ? aluSub : aluAdd;
            f3Sll: func = aluSll;
            f3Slt: func = aluSLess;
            f3Sltu: func = aluULess;
            f3Xor: func = aluXor;
            f3SrlSra: func = alt ? aluSra : aluSrl;
            f3Or: func = aluOr;
            f3And: func = aluAnd;
            default: func = aluUnknown;
        endcase
        return func;
    endfunction

    // only add/sub and the shifts exist as 32-bit word ops
    function automatic aluFuncT wordTable(input funct3T f3, input logic alt,
                                          input logic allowSub);
        aluFuncT func;
        unique case (f3)
            f3AddSub: func = (allowSub && alt) ? aluSubw : aluAddw;
            f3Sll: func = aluSllw;
            f3SrlSra: func = alt ? aluSraw : aluSrlw;
            default: func = aluUnknown;
        endcase
        return func;
    endfunction

    always_comb begin
        unique case (group)
            groupOpImm: begin
                aluFunc = fullTable(funct3, funct7Bit, 1'b0);
            end
            groupOp: begin
                aluFunc = fullTable(funct3, funct7Bit, 1'b1);
            end
            groupOpImm32: begin
                aluFunc = wordTable(funct3, funct7Bit, 1'b0);
            end
            groupOp32: begin
                aluFunc = wordTable(funct3, funct7Bit, 1'b1);
            end
            // address generation
            groupLoad, groupStore: begin
                aluFunc = aluAdd;
            end
            groupBranch: begin
                aluFunc = aluBranch;
            end
            groupLui, groupAuipc, groupJal, groupJalr: begin
                aluFunc = aluLink;
            end
            default: begin
                aluFunc = aluUnknown;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/branchDecode.sv
`timescale 1ns/10ps
`default_nettype none

module branchDecode
    import decodePkg::*;
(
    input wire instrGroup group,
    input wire funct3T funct3,
    output branchT branchType
);

    always_comb begin
        unique case (group)
            groupBranch: begin
                unique case (funct3)
                    f3Beq: branchType = brEq;
                    f3Bne: branchType = brNe;
                    f3Blt: branchType = brLessS;
                    f3Bltu: branchType = brLessU;
                    f3Bge: branchType = brGeS;
                    f3Bgeu: branchType = brGeU;
                    // 010 and 011 are reserved
                    default: branchType = noBranch;
                endcase
            end
            groupJal: begin
                branchType = brJal;
            end
            groupJalr: begin
                branchType = brJalr;
            end
            default: begin
                branchType = noBranch;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/decodePkg.sv
`default_nettype none

package decodePkg;

    localparam int xlen = 64;
    localparam int instrWidth = 32;
    // instruction bit that splits add/sub and logical/arithmetic shifts
    localparam int funct7AltBit = 30;

    typedef logic [xlen-1:0] dword;
    typedef logic [instrWidth-1:0] instrWord;
    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;

    // major opcodes
    localparam opcodeT opOpImm = 7'b0010011;
    localparam opcodeT opOp = 7'b0110011;
    localparam opcodeT opOpImm32 = 7'b0011011;
    localparam opcodeT opOp32 = 7'b0111011;
    localparam opcodeT opLoad = 7'b0000011;
    localparam opcodeT opStore = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opLui = 7'b0110111;
    localparam opcodeT opAuipc = 7'b0010111;
    localparam opcodeT opJal = 7'b1101111;
    localparam opcodeT opJalr = 7'b1100111;

    // integer ops shared by the register and immediate forms
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll = 3'b001;
    localparam funct3T f3Slt = 3'b010;
    localparam funct3T f3Sltu = 3'b011;
    localparam funct3T f3Xor = 3'b100;
    localparam funct3T f3SrlSra = 3'b101;
    localparam funct3T f3Or = 3'b110;
    localparam funct3T f3And = 3'b111;

    // load widths
    localparam funct3T f3Lb = 3'b000;
    localparam funct3T f3Lh = 3'b001;
    localparam funct3T f3Lw = 3'b010;
    localparam funct3T f3Ld = 3'b011;
    localparam funct3T f3Lbu = 3'b100;
    localparam funct3T f3Lhu = 3'b101;
    localparam funct3T f3Lwu = 3'b110;

    // store widths
    localparam funct3T f3Sb = 3'b000;
    localparam funct3T f3Sh = 3'b001;
    localparam funct3T f3Sw = 3'b010;
    localparam funct3T f3Sd = 3'b011;

    // branch compares
    localparam funct3T f3Beq = 3'b000;
    localparam funct3T f3Bne = 3'b001;
    localparam funct3T f3Blt = 3'b100;
    localparam funct3T f3Bge = 3'b101;
    localparam funct3T f3Bltu = 3'b110;
    localparam funct3T f3Bgeu = 3'b111;

    typedef enum logic [3:0] {
        groupOpImm,
        groupOp,
        groupOpImm32,
        groupOp32,
        groupLoad,
        groupStore,
        groupBranch,
        groupLui,
        groupAuipc,
        groupJal,
        groupJalr,
        groupIllegal
    } instrGroup;

    typedef enum logic [1:0] {
        noRegs,
        rs1Only,
        rs1AndRs2
    } regUseT;

    typedef enum logic [2:0] {
        fromReg,
        fromImm,
        fromShamt,
        fromPcAddImm,
        fromPcAdd4,
        noSrc
    } aluSrcT;

    typedef enum logic [2:0] {
        noImm,
        immI,
        immU,
        immB,
        immS,
        immJ
    } immTypeT;

    typedef enum logic [4:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluOr,
        aluAnd,
        aluSLess,
        aluULess,
        aluSll,
        aluSrl,
        aluSra,
        aluAddw,
        aluSubw,
        aluSllw,
        aluSrlw,
        aluSraw,
        aluBranch,
        aluLink,
        aluUnknown
    } aluFuncT;

    typedef enum logic [2:0] {
        sizeNone,
        size8,
        size16,
        size32,
        size64
    } memSizeT;

    // sext/zext from the named top bit
    typedef enum logic [3:0] {
        wbNone,
        wb7Sext,
        wb15Sext,
        wb31Sext,
        wb7Zext,
        wb15Zext,
        wb31Zext,
        wb63
    } wbTypeT;

    typedef enum logic [3:0] {
        noBranch,
        brEq,
        brNe,
        brLessS,
        brLessU,
        brGeS,
        brGeU,
        brJal,
        brJalr
    } branchT;

endpackage

`default_nettype wire

// File: src/instrFormatDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrFormatDecode
    import decodePkg::*;
(
    input wire dword pc,
    input wire opcodeT opcode,
    input wire funct3T funct3,
    output instrGroup group,
    output regUseT regUse,
    output logic regWrite,
    output aluSrcT aluSrc,
    output immTypeT immType,
    output logic instrMisalign
);

    // fetch address must be word aligned
    assign instrMisalign = |pc[1:0];

    always_comb begin
        group = groupIllegal;
        regUse = noRegs;
        regWrite = 1'b0;
        aluSrc = fromReg;
        immType = noImm;

        unique case (opcode)
            opOpImm: begin
                group = groupOpImm;
                regUse = rs1Only;
                regWrite = 1'b1;
                if (funct3 == f3Sll || funct3 == f3SrlSra) begin
                    aluSrc = fromShamt;
                    immType = noImm;
                end else begin
                    aluSrc = fromImm;
                    immType = immI;
                end
            end
            opOp: begin
                group = groupOp;
                regUse = rs1AndRs2;
                regWrite = 1'b1;
            end
            opOpImm32: begin
                group = groupOpImm32;
                regUse = rs1Only;
                regWrite = 1'b1;
                unique case (funct3)
                    f3AddSub: begin
                        aluSrc = fromImm;
                        immType = immI;
                    end
                    f3Sll, f3SrlSra: begin
                        aluSrc = fromShamt;
                        immType = noImm;
                    end
                    default: begin
                        // no word form for the other ops
                        aluSrc = noSrc;
                        immType = noImm;
                    end
                endcase
            end
            opOp32: begin
                group = groupOp32;
                regUse = rs1AndRs2;
                regWrite = 1'b1;
            end
            opLoad: begin
                group = groupLoad;
                regUse = rs1Only;
                regWrite = 1'b1;
                aluSrc = fromImm;
                immType = immI;
            end
            opStore: begin
                group = groupStore;
                regUse = rs1AndRs2;
                aluSrc = fromImm;
                immType = immS;
            end
            opBranch: begin
                group = groupBranch;
                regUse = rs1AndRs2;
                immType = immB;
            end
            opLui: begin
                group = groupLui;
                regWrite = 1'b1;
                aluSrc = fromImm;
                immType = immU;
            end
            opAuipc: begin
                group = groupAuipc;
                regWrite = 1'b1;
                aluSrc = fromPcAddImm;
                immType = immU;
            end
            opJal: begin
                group = groupJal;
                regWrite = 1'b1;
                aluSrc = fromPcAdd4;
                immType = immJ;
            end
            opJalr: begin
                group = groupJalr;
                regUse = rs1Only;
                regWrite = 1'b1;
                aluSrc = fromPcAdd4;
                immType = immI;
            end
            default: begin
                group = groupIllegal;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/memAccessDecode.sv
`timescale 1ns/10ps
`default_nettype none

module memAccessDecode
    import decodePkg::*;
(
    input wire instrGroup group,
    input wire funct3T funct3,
    output logic memRead,
    output logic memWrite,
    output logic memToReg,
    output memSizeT memSize,
    output wbTypeT wbType
);

    always_comb begin
        memRead = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        memSize = sizeNone;
        wbType = wbNone;

        if (group == groupLoad) begin
            memRead = 1'b1;
            memToReg = 1'b1;
            unique case (funct3)
                f3Lb: {memSize, wbType} = {size8, wb7Sext};
                f3Lh: {memSize, wbType} = {size16, wb15Sext};
                f3Lw: {memSize, wbType} = {size32, wb31Sext};
                f3Ld: {memSize, wbType} = {size64, wb63};
                f3Lbu: {memSize, wbType} = {size8, wb7Zext};
                f3Lhu: {memSize, wbType} = {size16, wb15Zext};
                f3Lwu: {memSize, wbType} = {size32, wb31Zext};
                default: begin
                    // no access at all for an undefined width
                    memRead = 1'b0;
                    memToReg = 1'b0;
                end
            endcase
        end else if (group == groupStore) begin
            memWrite = 1'b1;
            unique case (funct3)
                f3Sb: memSize = size8;
                f3Sh: memSize = size16;
                f3Sw: memSize = size32;
                f3Sd: memSize = size64;
                default: begin
                    memWrite = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/rv64Decoder.sv
`timescale 1ns/10ps
`default_nettype none

module rv64Decoder
    import decodePkg::*;
(
    input wire dword pc,
    input wire instrWord instr,
    output regUseT regUse,
    output logic regWrite,
    output aluSrcT aluSrc,
    output immTypeT immType,
    output aluFuncT aluFunc,
    output logic memRead,
    output logic memWrite,
    output logic memToReg,
    output memSizeT memSize,
    output wbTypeT wbType,
    output branchT branchType,
    output logic instrMisalign
);

    opcodeT opcode;
    funct3T funct3;
    logic funct7Bit;
    instrGroup group;

    // instruction fields
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7Bit = instr[funct7AltBit];

    instrFormatDecode format_i (
        .pc(pc),
        .opcode(opcode),
        .funct3(funct3),
        .group(group),
        .regUse(regUse),
        .regWrite(regWrite),
        .aluSrc(aluSrc),
        .immType(immType),
        .instrMisalign(instrMisalign)
    );

    aluFuncDecode alu_i (
        .group(group),
        .funct3(funct3),
        .funct7Bit(funct7Bit),
        .aluFunc(aluFunc)
    );

    memAccessDecode mem_i (
        .group(group),
        .funct3(funct3),
        .memRead(memRead),
        .memWrite(memWrite),
        .memToReg(memToReg),
        .memSize(memSize),
        .wbType(wbType)
    );

    branchDecode branch_i (
        .group(group),
        .funct3(funct3),
        .branchType(branchType)
    );

endmodule

`default_nettype wire
